// File: verilog/uart_pkg.sv
package uart_pkg;

    // one data byte on the serial line
    typedef logic [7:0] byte_t;

    // position in frame: 0 start, 1..8 data, 9 stop
    typedef logic [3:0] bit_idx_t;

    typedef enum logic [1:0] {
        rx_idle  = 2'd0,    // waiting for falling edge
        rx_start = 2'd1,    // checking start bit at mid point
        rx_data  = 2'd2,    // shifting in eight data bits
        rx_stop  = 2'd3     // sampling stop bit
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle  = 2'd0,    // line high, ready for strobe
        tx_start = 2'd1,    // driving start bit
        tx_data  = 2'd2,    // driving data bits lsb first
        tx_stop  = 2'd3     // driving stop bit
    } tx_state_t;

endpackage

// File: verilog/uart_rx.sv
module uart_rx #(
    parameter int os_rate = 16              // uart_clk cycles per bit
) (
    input  logic            uart_clk,
    input  logic            sys_rst_n,
    input  logic            rxd,
    output uart_pkg::byte_t rec_data,       // held until next frame
    output logic            rec_flag,       // one cycle per frame
    output logic            frame_err       // stop bit read as 0
);

    localparam int cnt_w = $clog2(os_rate);
    localparam logic [cnt_w-1:0] half_pt = cnt_w'(os_rate / 2 - 1);
    localparam logic [cnt_w-1:0] full_pt = cnt_w'(os_rate - 1);

    logic                rxd_m;             // first sync flop
    logic                rxd_s;             // synchronized line
    logic                rxd_d;             // previous synchronized value
    logic                start_edge;
    logic                stop_sample;
    logic                data_sample;
    uart_pkg::rx_state_t state;
    logic [cnt_w-1:0]    os_cnt;
    uart_pkg::bit_idx_t  bit_idx;
    uart_pkg::byte_t     temp_data;

    // two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rxd_m <= 1'b1;
            rxd_s <= 1'b1;
            rxd_d <= 1'b1;
        end else begin
            rxd_m <= rxd;
            rxd_s <= rxd_m;
            rxd_d <= rxd_s;
        end
    end

    // only a high-to-low transition starts a frame
    assign start_edge  = rxd_d & ~rxd_s;
    assign data_sample = (state == uart_pkg::rx_data) && (os_cnt == full_pt);
    assign stop_sample = (state == uart_pkg::rx_stop) && (os_cnt == full_pt);

    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= uart_pkg::rx_idle;
            os_cnt  <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                uart_pkg::rx_idle: begin
                    os_cnt  <= '0;
                    bit_idx <= '0;
                    if (start_edge) begin
                        state <= uart_pkg::rx_start;
                    end
                end
                uart_pkg::rx_start: begin
                    if (os_cnt == half_pt) begin
                        os_cnt <= '0;
                        if (rxd_s) begin
                            state <= uart_pkg::rx_idle;   // glitch, not a start
                        end else begin
                            state   <= uart_pkg::rx_data;
                            bit_idx <= 4'd1;
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_data: begin
                    if (os_cnt == full_pt) begin
                        os_cnt  <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 4'd8) begin
                            state <= uart_pkg::rx_stop;
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_stop: begin
                    if (os_cnt == full_pt) begin
                        os_cnt <= '0;
                        state  <= uart_pkg::rx_idle;
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::rx_idle;
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge uart_clk) begin
        if (data_sample) begin
            temp_data <= {rxd_s, temp_data[7:1]};
        end
    end

    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rec_data  <= '0;
            rec_flag  <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rec_flag <= stop_sample;
            if (stop_sample) begin
                rec_data  <= temp_data;
                frame_err <= ~rxd_s;            // byte still delivered
            end
        end
    end

endmodule

// File: verilog/uart_tx.sv
module uart_tx #(
    parameter int os_rate = 16              // uart_clk cycles per bit
) (
    input  logic            uart_clk,
    input  logic            sys_rst_n,
    input  uart_pkg::byte_t tx_data,        // captured with tx_start
    input  logic            tx_start,       // ignored while busy
    output logic            txd,
    output logic            tx_busy
);

    localparam int cnt_w = $clog2(os_rate);
    localparam logic [cnt_w-1:0] full_pt = cnt_w'(os_rate - 1);

    uart_pkg::tx_state_t state;
    logic [cnt_w-1:0]    os_cnt;
    uart_pkg::bit_idx_t  bit_idx;
    uart_pkg::byte_t     shift_reg;
    logic                accept;
    logic                bit_end;

    assign accept  = tx_start & ~tx_busy;
    assign bit_end = (os_cnt == full_pt);

    // payload shifter, bit 0 always holds the next data bit
    always_ff @(posedge uart_clk) begin
        if (accept) begin
            shift_reg <= tx_data;
        end else if (bit_end && (state == uart_pkg::tx_start ||
                                 state == uart_pkg::tx_data)) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    always_ff @(posedge uart_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state   <= uart_pkg::tx_idle;
            os_cnt  <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
            tx_busy <= 1'b0;
        end else begin
            case (state)
                uart_pkg::tx_idle: begin
                    os_cnt  <= '0;
                    bit_idx <= '0;
                    txd     <= 1'b1;
                    if (accept) begin
                        state   <= uart_pkg::tx_start;
                        txd     <= 1'b0;        // start bit
                        tx_busy <= 1'b1;
                    end
                end
                uart_pkg::tx_start: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        state   <= uart_pkg::tx_data;
                        bit_idx <= 4'd1;
                        txd     <= shift_reg[0];
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 4'd8) begin
                            state <= uart_pkg::tx_stop;
                            txd   <= 1'b1;      // stop bit
                        end else begin
                            txd <= shift_reg[0];
                        end
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_stop: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        state   <= uart_pkg::tx_idle;
                        tx_busy <= 1'b0;        // ten bit periods after rise
                    end else begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: begin
                    state   <= uart_pkg::tx_idle;
                    txd     <= 1'b1;
                    tx_busy <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: verilog/uart_top.sv
module uart_top #(
    parameter int os_rate = 16              // oversampling for both directions
) (
    input  logic            uart_clk,       // os_rate times the baud rate
    input  logic            sys_rst_n,

    // receive side
    input  logic            rxd,
    output uart_pkg::byte_t rec_data,
    output logic            rec_flag,
    output logic            frame_err,

    // transmit side
    input  uart_pkg::byte_t tx_data,
    input  logic            tx_start,
    output logic            txd,
    output logic            tx_busy
);

    // receiver and transmitter are independent, sharing clock and reset only

    uart_rx #(
        .os_rate   (os_rate)
    ) rx_i (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .rxd       (rxd),
        .rec_data  (rec_data),
        .rec_flag  (rec_flag),
        .frame_err (frame_err)
    );

    uart_tx #(
        .os_rate   (os_rate)
    ) tx_i (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .txd       (txd),
        .tx_busy   (tx_busy)
    );

endmodule

// File: verification/uart_tb.sv
module uart_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int os_rate      = 16;
    localparam int frame_cycles = 10 * os_rate;
    localparam int wait_limit   = 3 * frame_cycles;     // cycles before a wait gives up
    localparam int num_rows     = 9;
    localparam int num_random   = 8;

    typedef struct packed {
        uart_pkg::byte_t data;
        logic            stop_bit;
        logic [7:0]      start_len;     // below os_rate means a glitch
    } row_t;

    logic            uart_clk = 1'b0;
    logic            sys_rst_n;
    logic            rxd_drv;
    logic            loopback;          // feeds txd back into rxd
    logic            rxd;
    uart_pkg::byte_t rec_data;
    logic            rec_flag;
    logic            frame_err;
    uart_pkg::byte_t tx_data;
    logic            tx_start;
    logic            txd;
    logic            tx_busy;

    int              rec_count = 0;     // rec_flag pulses seen
    int              expected_rx = 0;   // pulses the stimulus should have caused
    uart_pkg::byte_t last_data;
    logic            last_err;
    logic [31:0]     lfsr_state = 32'hc93f6b6d;

    row_t stim_rows [num_rows] = '{
        '{8'h00, 1'b1, 8'd16},          // rows 0 to 3 back to back
        '{8'hff, 1'b1, 8'd16},
        '{8'h55, 1'b1, 8'd16},
        '{8'ha5, 1'b1, 8'd16},
        '{8'h3c, 1'b0, 8'd16},          // framing error
        '{8'h81, 1'b1, 8'd16},          // clears frame_err
        '{8'h7e, 1'b1, 8'd4},           // start glitch
        '{8'hc3, 1'b1, 8'd16},
        '{8'h0f, 1'b1, 8'd16}
    };

    assign rxd = loopback ? txd : rxd_drv;

    uart_top #(
        .os_rate   (os_rate)
    ) dut_i (
        .uart_clk  (uart_clk),
        .sys_rst_n (sys_rst_n),
        .rxd       (rxd),
        .rec_data  (rec_data),
        .rec_flag  (rec_flag),
        .frame_err (frame_err),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .txd       (txd),
        .tx_busy   (tx_busy)
    );

    initial begin
        forever #5 uart_clk = ~uart_clk;
    end

    // values before the edge, so the pulse of the previous cycle
    always @(posedge uart_clk) begin
        if (rec_flag) begin
            rec_count = rec_count + 1;
            last_data = rec_data;
            last_err  = frame_err;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0d ns: no %s within %0d cycles", $time, what, wait_limit);
        $display("sim failed");
        $fatal(1, "wait timed out");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_byte(output uart_pkg::byte_t b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i]       = lfsr_state[0];
        end
    endtask

    // called right after a falling edge
    task automatic drive_line(input logic value, input int cycles);
        rxd_drv = value;
        repeat (cycles) @(negedge uart_clk);
    endtask

    task automatic send_frame(input uart_pkg::byte_t data, input logic stop_bit,
                              input int start_len);
        int i;
        drive_line(1'b0, start_len);
        if (start_len < os_rate) begin
            drive_line(1'b1, frame_cycles - start_len);     // rest of a frame idle
        end else begin
            for (i = 0; i < 8; i++) begin
                drive_line(data[i], os_rate);
            end
            drive_line(stop_bit, os_rate);
            if (!stop_bit) begin
                drive_line(1'b1, os_rate);  // next start needs a falling edge
            end
        end
    endtask

    task automatic wait_rec_count(input int target);
        int n;
        n = 0;
        while (rec_count < target) begin
            @(negedge uart_clk);
            n++;
            if (n > wait_limit) report_timeout("rec_flag pulse");
        end
    endtask

    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_busy !== 1'b0) begin
            @(negedge uart_clk);
            n++;
            if (n > wait_limit) report_timeout("idle transmitter");
        end
    endtask

    task automatic read_txd_frame(output uart_pkg::byte_t data, output logic stop_bit);
        int n;
        int i;
        n = 0;
        while (txd !== 1'b0) begin
            @(negedge uart_clk);
            n++;
            if (n > wait_limit) report_timeout("falling edge on txd");
        end
        repeat (os_rate / 2 - 1) @(negedge uart_clk);    // middle of start bit
        check("txd start bit", txd, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (os_rate) @(negedge uart_clk);
            data[i] = txd;
        end
        repeat (os_rate) @(negedge uart_clk);
        stop_bit = txd;
    endtask

    task automatic receive_and_check(input row_t row);
        logic exp_err;
        exp_err = !row.stop_bit;
        send_frame(row.data, row.stop_bit, row.start_len);
        if (row.start_len < os_rate) begin
            check("rec_flag count after glitch", rec_count, expected_rx);
        end else begin
            expected_rx++;
            wait_rec_count(expected_rx);
            check("rec_flag count", rec_count, expected_rx);
            check("rec_data", last_data, row.data);
            check("frame_err", last_err, exp_err);
        end
    endtask

    task automatic transmit_and_check(input uart_pkg::byte_t data);
        uart_pkg::byte_t got_data;
        logic            got_stop;
        int              busy_cycles;
        wait_tx_idle();
        fork
            read_txd_frame(got_data, got_stop);
            begin
                tx_data  = data;
                tx_start = 1'b1;
                @(negedge uart_clk);
                tx_start = 1'b0;
                check("tx_busy after strobe", tx_busy, 1'b1);
                busy_cycles = 0;
                while (tx_busy) begin
                    tx_start = (busy_cycles == 2);  // stray strobe while busy
                    tx_data  = ~data;
                    @(negedge uart_clk);
                    busy_cycles++;
                    if (busy_cycles > wait_limit) report_timeout("fall of tx_busy");
                end
                tx_start = 1'b0;
                check("tx_busy cycles", busy_cycles, frame_cycles);
            end
        join
        check("txd data", got_data, data);
        check("txd stop bit", got_stop, 1'b1);
    endtask

    initial begin
        int              r;
        int              k;
        uart_pkg::byte_t rnd;
        sys_rst_n = 1'b0;
        rxd_drv   = 1'b1;
        loopback  = 1'b0;
        tx_data   = '0;
        tx_start  = 1'b0;
        repeat (10) @(negedge uart_clk);
        sys_rst_n = 1'b1;
        @(negedge uart_clk);

        check("txd", txd, 1'b1);
        check("tx_busy", tx_busy, 1'b0);
        check("rec_flag", rec_flag, 1'b0);
        check("frame_err", frame_err, 1'b0);
        check("rec_data", rec_data, 8'h00);

        for (r = 0; r < num_rows; r++) begin
            receive_and_check(stim_rows[r]);
        end
        for (r = 0; r < num_rows; r++) begin
            transmit_and_check(stim_rows[r].data);
        end

        loopback = 1'b1;                    // both lines idle high here
        for (k = 0; k < num_random; k++) begin
            take_random_byte(rnd);
            expected_rx++;
            transmit_and_check(rnd);
            wait_rec_count(expected_rx);
            check("loopback rec_data", last_data, rnd);
            check("loopback frame_err", last_err, 1'b0);
        end
        loopback = 1'b0;

        repeat (os_rate) @(negedge uart_clk);
        check("rec_flag total", rec_count, expected_rx);
        $display("sim passed");
        $finish;
    end

endmodule

// File: compile.f
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_top.sv
verification/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the uart testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
rm -f "$build_log" "$sim_log"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module uart_tb -o uart_sim -f compile.f > "$build_log" 2>&1
build_status=$?
cat "$build_log"
if [ $build_status -ne 0 ]; then
    echo "verilator build returned status $build_status"
    exit 1
fi

./obj_dir/uart_sim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"

# the log decides the result
if grep -q "sim failed" "$sim_log"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi
exit 0
